/* common/preamble_pkg.sv */
package preamble_pkg;

  // signed I or Q sample
  localparam int SAMPLE_W = 16;

  // window sum component, headroom for LEN up to 256
  localparam int SUM_W = SAMPLE_W + 8;

  // fraction of the power magnitude used as trigger threshold
  typedef enum logic [1:0] {
    RATIO_1_4,
    RATIO_3_8,
    RATIO_1_2,
    RATIO_5_8
  } thres_ratio_e;

  typedef enum logic [1:0] {
    PK_IDLE,  // no trigger run
    PK_COUNT, // counting consecutive triggers
    PK_HOLD   // strobed, wait for a miss
  } peak_state_e;

endpackage

/* common/iq_stream_if.sv */
`timescale 1ns/1ps

interface iq_stream_if #(
  parameter int W = 16
) ();

  logic                valid;
  logic signed [W-1:0] i;
  logic signed [W-1:0] q;

  modport src (
    output valid,
    output i,
    output q
  );

  modport snk (
    input valid,
    input i,
    input q
  );

endinterface

/* source/iq_decimator.sv */
`timescale 1ns/1ps

module iq_decimator #(
  parameter int DEC_RATE = 4
) (
  input  logic                                    clk,
  input  logic                                    i_arst_n,
  input  logic                                    i_clear,
  input  logic                                    i_valid,
  input  logic signed [preamble_pkg::SAMPLE_W-1:0] i_i,
  input  logic signed [preamble_pkg::SAMPLE_W-1:0] i_q,
  iq_stream_if.src                                o_dec
);
  import preamble_pkg::*;

  localparam int ACC_W = SAMPLE_W + 8;

  logic [7:0]              cnt;
  logic                    last;
  logic signed [ACC_W-1:0] acc_i, acc_q;
  logic signed [ACC_W-1:0] sum_i, sum_q;
  logic signed [ACC_W-1:0] shf_i, shf_q;

  assign last  = (cnt == 8'(DEC_RATE - 1));
  assign sum_i = acc_i + i_i;
  assign sum_q = acc_q + i_q;
  assign shf_i = sum_i >>> 8; // fixed scaling of the block sum
  assign shf_q = sum_q >>> 8;

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      cnt         <= '0;
      acc_i       <= '0;
      acc_q       <= '0;
      o_dec.valid <= 1'b0;
    end else if (i_clear) begin
      cnt         <= '0;
      acc_i       <= '0;
      acc_q       <= '0;
      o_dec.valid <= 1'b0;
    end else begin
      o_dec.valid <= i_valid && last;
      if (i_valid) begin
        if (last) begin
          cnt   <= '0;
          acc_i <= '0; // next block starts on the following valid
          acc_q <= '0;
        end else begin
          cnt   <= cnt + 8'd1;
          acc_i <= sum_i;
          acc_q <= sum_q;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (i_valid && last) begin
      o_dec.i <= shf_i[SAMPLE_W-1:0];
      o_dec.q <= shf_q[SAMPLE_W-1:0];
    end
  end

endmodule

/* correlator/delay_correlator.sv */
`timescale 1ns/1ps

module delay_correlator #(
  parameter int LEN = 16
) (
  input  logic     clk,
  input  logic     i_arst_n,
  input  logic     i_clear,
  iq_stream_if.snk i_dec,
  iq_stream_if.src o_pow,
  iq_stream_if.src o_acr
);
  import preamble_pkg::*;

  localparam int PTR_W  = $clog2(LEN);
  localparam int FILL_W = $clog2(LEN + 1);
  localparam int PROD_W = 2 * SAMPLE_W + 1;

  logic signed [SAMPLE_W-1:0] mem_i [LEN];
  logic signed [SAMPLE_W-1:0] mem_q [LEN];
  logic [PTR_W-1:0]           wptr;
  logic [FILL_W-1:0]          fill;
  logic                       full;
  logic                       x_valid;
  logic signed [SAMPLE_W-1:0] x_i, x_q;
  logic signed [SAMPLE_W-1:0] z_i, z_q;
  logic signed [PROD_W-1:0]   pow_re, acr_re, acr_im;
  logic signed [PROD_W-1:0]   pow_sh, acr_re_sh, acr_im_sh;

  assign full = (fill == FILL_W'(LEN));

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      wptr        <= '0;
      fill        <= '0;
      x_valid     <= 1'b0;
      o_pow.valid <= 1'b0;
      o_acr.valid <= 1'b0;
    end else if (i_clear) begin
      wptr        <= '0;
      fill        <= '0; // z reads as zero again
      x_valid     <= 1'b0;
      o_pow.valid <= 1'b0;
      o_acr.valid <= 1'b0;
    end else begin
      x_valid     <= i_dec.valid;
      o_pow.valid <= x_valid;
      o_acr.valid <= x_valid;
      if (i_dec.valid) begin
        wptr <= (wptr == PTR_W'(LEN - 1)) ? '0 : wptr + 1'b1;
        if (!full) begin
          fill <= fill + 1'b1;
        end
      end
    end
  end

  // oldest entry is read before it is overwritten
  always_ff @(posedge clk) begin
    if (i_dec.valid) begin
      mem_i[wptr] <= i_dec.i;
      mem_q[wptr] <= i_dec.q;
      x_i         <= i_dec.i;
      x_q         <= i_dec.q;
      z_i         <= full ? mem_i[wptr] : '0;
      z_q         <= full ? mem_q[wptr] : '0;
    end
  end

  assign pow_re = x_i * x_i + x_q * x_q;
  assign acr_re = x_i * z_i + x_q * z_q; // x * conj(z)
  assign acr_im = x_q * z_i - x_i * z_q;

  assign pow_sh    = pow_re >>> (SAMPLE_W - 1);
  assign acr_re_sh = acr_re >>> (SAMPLE_W - 1);
  assign acr_im_sh = acr_im >>> (SAMPLE_W - 1);

  always_ff @(posedge clk) begin
    if (x_valid) begin
      o_pow.i <= pow_sh[SAMPLE_W-1:0];
      o_pow.q <= '0; // power is real
      o_acr.i <= acr_re_sh[SAMPLE_W-1:0];
      o_acr.q <= acr_im_sh[SAMPLE_W-1:0];
    end
  end

endmodule

/* correlator/moving_sum.sv */
`timescale 1ns/1ps

module moving_sum #(
  parameter int LEN = 16
) (
  input  logic     clk,
  input  logic     i_arst_n,
  input  logic     i_clear,
  iq_stream_if.snk i_item,
  iq_stream_if.src o_sum
);
  import preamble_pkg::*;

  localparam int PTR_W  = $clog2(LEN);
  localparam int FILL_W = $clog2(LEN + 1);

  logic signed [SAMPLE_W-1:0] hist_i [LEN];
  logic signed [SAMPLE_W-1:0] hist_q [LEN];
  logic [PTR_W-1:0]           wptr;
  logic [FILL_W-1:0]          fill;
  logic signed [SAMPLE_W-1:0] old_i, old_q;
  logic signed [SUM_W-1:0]    acc_i, acc_q;

  // item leaving the window, zero until the window is full
  assign old_i = (fill == FILL_W'(LEN)) ? hist_i[wptr] : '0;
  assign old_q = (fill == FILL_W'(LEN)) ? hist_q[wptr] : '0;

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      wptr        <= '0;
      fill        <= '0;
      acc_i       <= '0;
      acc_q       <= '0;
      o_sum.valid <= 1'b0;
    end else if (i_clear) begin
      wptr        <= '0;
      fill        <= '0;
      acc_i       <= '0;
      acc_q       <= '0;
      o_sum.valid <= 1'b0;
    end else begin
      o_sum.valid <= i_item.valid;
      if (i_item.valid) begin
        wptr  <= (wptr == PTR_W'(LEN - 1)) ? '0 : wptr + 1'b1;
        fill  <= (fill == FILL_W'(LEN)) ? fill : fill + 1'b1;
        acc_i <= acc_i + i_item.i - old_i;
        acc_q <= acc_q + i_item.q - old_q;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (i_item.valid) begin
      hist_i[wptr] <= i_item.i;
      hist_q[wptr] <= i_item.q;
    end
  end

  assign o_sum.i = acc_i;
  assign o_sum.q = acc_q;

endmodule

/* source/trigger_metric.sv */
`timescale 1ns/1ps

module trigger_metric #(
  parameter preamble_pkg::thres_ratio_e THRES = preamble_pkg::RATIO_3_8,
  parameter logic [preamble_pkg::SUM_W-1:0] NOISE_POW = 64
) (
  input  logic                           clk,
  input  logic                           i_arst_n,
  input  logic                           i_clear,
  iq_stream_if.snk                       i_psum,
  iq_stream_if.snk                       i_asum,
  output logic                           o_trig_valid,
  output logic                           o_trig,
  output logic [preamble_pkg::SUM_W-1:0] o_pow_mag,
  output logic [preamble_pkg::SUM_W-1:0] o_corr_mag
);
  import preamble_pkg::*;

  logic             mag_valid;
  logic [SUM_W-1:0] pow_mag, corr_mag;
  logic [SUM_W-1:0] thres;

  // max(|re|,|im|) + min(|re|,|im|)/2
  function automatic logic [SUM_W-1:0] mag_approx(input logic signed [SUM_W-1:0] re,
                                                  input logic signed [SUM_W-1:0] im);
    logic [SUM_W-1:0] a_re;
    logic [SUM_W-1:0] a_im;
    a_re = re[SUM_W-1] ? -re : re;
    a_im = im[SUM_W-1] ? -im : im;
    if (a_re > a_im) begin
      mag_approx = a_re + (a_im >> 1);
    end else begin
      mag_approx = a_im + (a_re >> 1);
    end
  endfunction

  always_comb begin
    case (THRES)
      RATIO_1_4: thres = pow_mag >> 2;
      RATIO_3_8: thres = (pow_mag >> 2) + (pow_mag >> 3);
      RATIO_1_2: thres = pow_mag >> 1;
      default:   thres = (pow_mag >> 1) + (pow_mag >> 3);
    endcase
  end

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      mag_valid    <= 1'b0;
      o_trig_valid <= 1'b0;
      o_trig       <= 1'b0;
    end else if (i_clear) begin
      mag_valid    <= 1'b0;
      o_trig_valid <= 1'b0;
      o_trig       <= 1'b0;
    end else begin
      mag_valid    <= i_psum.valid && i_asum.valid;
      o_trig_valid <= mag_valid;
      if (mag_valid) begin
        o_trig <= (corr_mag > thres) && (pow_mag > NOISE_POW);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (i_psum.valid && i_asum.valid) begin
      pow_mag  <= mag_approx(i_psum.i, i_psum.q);
      corr_mag <= mag_approx(i_asum.i, i_asum.q);
    end
    if (mag_valid) begin
      o_pow_mag  <= pow_mag; // kept in step with o_trig
      o_corr_mag <= corr_mag;
    end
  end

endmodule

/* source/peak_detect.sv */
`timescale 1ns/1ps

module peak_detect #(
  parameter int NRX_TRIG = 4
) (
  input  logic                           clk,
  input  logic                           i_arst_n,
  input  logic                           i_clear,
  input  logic                           i_trig_valid,
  input  logic                           i_trig,
  input  logic [preamble_pkg::SUM_W-1:0] i_pow_mag,
  input  logic [preamble_pkg::SUM_W-1:0] i_corr_mag,
  output logic                           o_metric_valid,
  output logic                           o_peak_stb,
  output logic [preamble_pkg::SUM_W-1:0] o_pow_mag,
  output logic [preamble_pkg::SUM_W-1:0] o_corr_mag
);
  import preamble_pkg::*;

  peak_state_e state;
  logic [7:0]  run_cnt;
  logic        hit;

  // this trigger completes the run
  assign hit = i_trig_valid && i_trig && (state != PK_HOLD) &&
               (run_cnt + 8'd1 == 8'(NRX_TRIG));

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state          <= PK_IDLE;
      run_cnt        <= '0;
      o_metric_valid <= 1'b0;
      o_peak_stb     <= 1'b0;
    end else if (i_clear) begin
      state          <= PK_IDLE;
      run_cnt        <= '0;
      o_metric_valid <= 1'b0;
      o_peak_stb     <= 1'b0;
    end else begin
      o_metric_valid <= i_trig_valid;
      o_peak_stb     <= hit;
      if (i_trig_valid) begin
        if (!i_trig) begin
          state   <= PK_IDLE; // rearm
          run_cnt <= '0;
        end else if (hit) begin
          state   <= PK_HOLD;
          run_cnt <= '0;
        end else if (state != PK_HOLD) begin
          state   <= PK_COUNT;
          run_cnt <= run_cnt + 8'd1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (i_trig_valid) begin
      o_pow_mag  <= i_pow_mag;
      o_corr_mag <= i_corr_mag;
    end
  end

endmodule

/* source/preamble_detect.sv */
`timescale 1ns/1ps

module preamble_detect #(
  parameter int DEC_RATE = 4,
  parameter int LEN      = 16,
  parameter int NRX_TRIG = 4,
  parameter logic [preamble_pkg::SUM_W-1:0] NOISE_POW = 64,
  parameter preamble_pkg::thres_ratio_e THRES = preamble_pkg::RATIO_3_8
) (
  input  logic                                    clk,
  input  logic                                    i_arst_n,
  input  logic                                    i_clear,
  input  logic                                    i_valid,
  input  logic signed [preamble_pkg::SAMPLE_W-1:0] i_i,
  input  logic signed [preamble_pkg::SAMPLE_W-1:0] i_q,
  output logic                                    o_metric_valid,
  output logic        [preamble_pkg::SUM_W-1:0]   o_pow_mag,
  output logic        [preamble_pkg::SUM_W-1:0]   o_corr_mag,
  output logic                                    o_peak_stb
);
  import preamble_pkg::*;

  iq_stream_if #(.W(SAMPLE_W)) dec_if ();
  iq_stream_if #(.W(SAMPLE_W)) pow_if ();
  iq_stream_if #(.W(SAMPLE_W)) acr_if ();
  iq_stream_if #(.W(SUM_W))    psum_if ();
  iq_stream_if #(.W(SUM_W))    asum_if ();

  logic             trig_valid;
  logic             trig;
  logic [SUM_W-1:0] pow_mag;
  logic [SUM_W-1:0] corr_mag;

  iq_decimator #(.DEC_RATE(DEC_RATE)) u_dec (
    .clk(clk), .i_arst_n(i_arst_n), .i_clear(i_clear),
    .i_valid(i_valid), .i_i(i_i), .i_q(i_q), .o_dec(dec_if.src)
  );

  delay_correlator #(.LEN(LEN)) u_corr (
    .clk(clk), .i_arst_n(i_arst_n), .i_clear(i_clear),
    .i_dec(dec_if.snk), .o_pow(pow_if.src), .o_acr(acr_if.src)
  );

  moving_sum #(.LEN(LEN)) POW (
    .clk(clk), .i_arst_n(i_arst_n), .i_clear(i_clear),
    .i_item(pow_if.snk), .o_sum(psum_if.src)
  );

  moving_sum #(.LEN(LEN)) ACR (
    .clk(clk), .i_arst_n(i_arst_n), .i_clear(i_clear),
    .i_item(acr_if.snk), .o_sum(asum_if.src)
  );

  trigger_metric #(.THRES(THRES), .NOISE_POW(NOISE_POW)) u_trig (
    .clk(clk), .i_arst_n(i_arst_n), .i_clear(i_clear),
    .i_psum(psum_if.snk), .i_asum(asum_if.snk),
    .o_trig_valid(trig_valid), .o_trig(trig),
    .o_pow_mag(pow_mag), .o_corr_mag(corr_mag)
  );

  peak_detect #(.NRX_TRIG(NRX_TRIG)) u_peak (
    .clk(clk), .i_arst_n(i_arst_n), .i_clear(i_clear),
    .i_trig_valid(trig_valid), .i_trig(trig),
    .i_pow_mag(pow_mag), .i_corr_mag(corr_mag),
    .o_metric_valid(o_metric_valid), .o_peak_stb(o_peak_stb),
    .o_pow_mag(o_pow_mag), .o_corr_mag(o_corr_mag)
  );

endmodule

/* tests/preamble_detect_assert.sv */
`timescale 1ns/1ps

module preamble_detect_assert (
  input logic clk,
  input logic i_arst_n,
  input logic i_clear,
  input logic o_metric_valid,
  input logic o_peak_stb
);

  logic armed; // a non-strobe metric was seen since the last strobe

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      armed <= 1'b1;
    end else if (i_clear) begin
      armed <= 1'b1;
    end else if (o_metric_valid) begin
      armed <= !o_peak_stb;
    end
  end

  stb_with_valid: assert property (@(posedge clk) disable iff (!i_arst_n)
    o_peak_stb |-> o_metric_valid) else $error("strobe without a metric");

  stb_rearmed: assert property (@(posedge clk) disable iff (!i_arst_n)
    o_peak_stb |-> armed) else $error("second strobe without a miss between");

  quiet_on_clear: assert property (@(posedge clk)
    (!i_arst_n || i_clear) |=> (!o_metric_valid && !o_peak_stb))
    else $error("outputs active after reset or clear");

endmodule

bind preamble_detect preamble_detect_assert u_assert (
  .clk(clk),
  .i_arst_n(i_arst_n),
  .i_clear(i_clear),
  .o_metric_valid(o_metric_valid),
  .o_peak_stb(o_peak_stb)
);

/* tests/tb_preamble_detect.sv */
`timescale 1ns/1ps

module tb_preamble_detect;
  import preamble_pkg::*;

  localparam int DEC_RATE = 4;
  localparam int LEN      = 16;
  localparam int NRX_TRIG = 4;
  localparam logic [SUM_W-1:0] NOISE_POW = 64;
  localparam thres_ratio_e THRES = RATIO_3_8;

  logic                       clk;
  logic                       i_arst_n;
  logic                       i_clear;
  logic                       i_valid;
  logic signed [SAMPLE_W-1:0] i_i;
  logic signed [SAMPLE_W-1:0] i_q;
  logic                       o_metric_valid;
  logic [SUM_W-1:0]           o_pow_mag;
  logic [SUM_W-1:0]           o_corr_mag;
  logic                       o_peak_stb;

  integer seed;
  int     cyc = 0;
  int     in_i[$];
  int     in_q[$];
  int     lat_q[$]; // expected arrival cycle per block
  int     pat_i[LEN];
  int     pat_q[LEN];
  int     blk, mcount, run;
  bit     hold;
  int     errors, checks, tests, err_at_start;
  int     seen, stb_cnt, trig_cnt;
  string  cur_test;

  preamble_detect #(
    .DEC_RATE(DEC_RATE), .LEN(LEN), .NRX_TRIG(NRX_TRIG),
    .NOISE_POW(NOISE_POW), .THRES(THRES)
  ) UUT (
    .clk(clk), .i_arst_n(i_arst_n), .i_clear(i_clear), .i_valid(i_valid),
    .i_i(i_i), .i_q(i_q), .o_metric_valid(o_metric_valid),
    .o_pow_mag(o_pow_mag), .o_corr_mag(o_corr_mag), .o_peak_stb(o_peak_stb)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) cyc <= cyc + 1;

  function automatic longint trunc16(input longint v);
    logic signed [15:0] t;
    t = v[15:0];
    return longint'(t);
  endfunction

  // decimated sample j as the block sum scaled by 2^-8
  function automatic longint dec_comp(input int j, input bit use_q);
    longint s;
    s = 0;
    for (int t = 0; t < DEC_RATE; t++) begin
      s += use_q ? in_q[j*DEC_RATE+t] : in_i[j*DEC_RATE+t];
    end
    return trunc16(s >>> 8);
  endfunction

  function automatic longint mag(input longint re, input longint im);
    longint a;
    longint b;
    longint m;
    a = (re < 0) ? -re : re;
    b = (im < 0) ? -im : im;
    m = (a > b) ? a + (b >> 1) : b + (a >> 1);
    return m & ((64'd1 << SUM_W) - 1);
  endfunction

  function automatic void ref_metric(input int m, output logic [SUM_W-1:0] pm,
                                     output logic [SUM_W-1:0] cm, output bit tr);
    longint p_re, a_re, a_im, xi, xq, zi, zq;
    logic [SUM_W-1:0] thr;
    p_re = 0;
    a_re = 0;
    a_im = 0;
    for (int j = (m - LEN + 1 < 0) ? 0 : m - LEN + 1; j <= m; j++) begin
      xi = dec_comp(j, 0);
      xq = dec_comp(j, 1);
      zi = (j < LEN) ? 0 : dec_comp(j - LEN, 0);
      zq = (j < LEN) ? 0 : dec_comp(j - LEN, 1);
      p_re += trunc16((xi*xi + xq*xq) >>> (SAMPLE_W - 1));
      a_re += trunc16((xi*zi + xq*zq) >>> (SAMPLE_W - 1));
      a_im += trunc16((xq*zi - xi*zq) >>> (SAMPLE_W - 1));
    end
    pm = SUM_W'(mag(p_re, 0));
    cm = SUM_W'(mag(a_re, a_im));
    case (THRES)
      RATIO_1_4: thr = pm >> 2;
      RATIO_3_8: thr = (pm >> 2) + (pm >> 3);
      RATIO_1_2: thr = pm >> 1;
      default:   thr = (pm >> 1) + (pm >> 3);
    endcase
    tr = (cm > thr) && (pm > NOISE_POW);
  endfunction

  task automatic report_value(input string what, input longint exp, input longint act);
    $display("ERROR %s %s expected %0d actual %0d", cur_test, what, exp, act);
    errors++;
  endtask

  task automatic check_metric();
    logic [SUM_W-1:0] e_pm, e_cm;
    bit e_tr, e_stb;
    int e_cyc;
    ref_metric(mcount, e_pm, e_cm, e_tr);
    e_stb = 1'b0;
    if (!e_tr) begin
      run  = 0;
      hold = 1'b0;
    end else if (!hold) begin
      run++;
      if (run == NRX_TRIG) begin
        e_stb = 1'b1;
        hold  = 1'b1;
        run   = 0;
      end
    end
    if (lat_q.size() == 0) begin
      $display("ERROR %s metric arrived without a completed block", cur_test);
      errors++;
    end else begin
      e_cyc = lat_q.pop_front();
      assert (cyc == e_cyc) else report_value("latency", e_cyc, cyc);
    end
    assert (o_pow_mag == e_pm) else report_value("pow_mag", e_pm, o_pow_mag);
    assert (o_corr_mag == e_cm) else report_value("corr_mag", e_cm, o_corr_mag);
    assert (o_peak_stb == e_stb) else report_value("peak_stb", e_stb, o_peak_stb);
    checks += 4;
    mcount++;
    seen++;
    if (e_tr) trig_cnt++;
    if (o_peak_stb) stb_cnt++;
  endtask

  // model restarts when clear is seen
  initial begin
    forever begin
      @(negedge clk);
      if (o_metric_valid) check_metric();
      if (i_clear) begin
        in_i.delete();
        in_q.delete();
        lat_q.delete();
        mcount = 0;
        run    = 0;
        hold   = 1'b0;
      end
    end
  end

  task automatic send(input int vi, input int vq);
    @(posedge clk);
    i_valid <= 1'b1;
    i_i     <= 16'(vi);
    i_q     <= 16'(vq);
    in_i.push_back(vi);
    in_q.push_back(vq);
    blk++;
    if (blk == DEC_RATE) begin
      blk = 0;
      lat_q.push_back(cyc + 8); // valid 7 cycles after this edge
    end
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clk);
      i_valid <= 1'b0;
    end
  endtask

  task automatic send_noise(input int blocks, input int amp);
    repeat (blocks * DEC_RATE) send($random(seed) % amp, $random(seed) % amp);
  endtask

  task automatic send_pattern(input int periods, input int div, input int amp);
    for (int p = 0; p < periods; p++) begin
      for (int k = 0; k < LEN; k++) begin
        repeat (DEC_RATE) begin
          send(pat_i[k] / div + $random(seed) % amp, pat_q[k] / div + $random(seed) % amp);
        end
      end
    end
  endtask

  task automatic pulse_clear();
    @(posedge clk);
    i_valid <= 1'b0;
    i_clear <= 1'b1;
    blk = 0;
    @(posedge clk);
    i_clear <= 1'b0;
    @(negedge clk);
    assert (!o_metric_valid && !o_peak_stb) else begin
      $display("ERROR %s outputs still active after clear", cur_test);
      errors++;
    end
  endtask

  task automatic abort_run(input string why);
    $display("timeout: %s", why);
    $display("ERRORS FOUND");
    $finish;
  endtask

  task automatic drain();
    int t;
    idle(1);
    for (t = 0; t < 100 && lat_q.size() != 0; t++) @(negedge clk);
    if (lat_q.size() != 0) begin
      abort_run("metrics did not arrive");
    end else begin
      idle(10); // room for stray metrics
    end
  endtask

  task automatic start_test(input string name);
    cur_test     = name;
    err_at_start = errors;
    seen         = 0;
    stb_cnt      = 0;
    trig_cnt     = 0;
  endtask

  task automatic end_test();
    tests++;
    $display("%s: %s (%0d metrics, %0d triggers, %0d strobes)", cur_test,
             (errors == err_at_start) ? "pass" : "fail", seen, trig_cnt, stb_cnt);
  endtask

  initial begin
    seed     = 7329;
    i_arst_n = 1'b0;
    i_clear  = 1'b0;
    i_valid  = 1'b0;
    i_i      = '0;
    i_q      = '0;
    blk      = 0;
    mcount   = 0;
    run      = 0;
    hold     = 1'b0;
    errors   = 0;
    checks   = 0;
    tests    = 0;
    for (int k = 0; k < LEN; k++) begin
      pat_i[k] = (($random(seed) & 1) != 0) ? 20000 + ($random(seed) & 8191)
                                            : -20000 - ($random(seed) & 8191);
      pat_q[k] = (($random(seed) & 1) != 0) ? 20000 + ($random(seed) & 8191)
                                            : -20000 - ($random(seed) & 8191);
    end
    repeat (5) @(posedge clk);
    i_arst_n <= 1'b1;

    start_test("decimation_latency");
    for (int n = 0; n < 32; n++) begin
      send(n * 300 - 4000, 2000 - n * 150);
      if (n % 3 == 1) idle(n % 4 + 1); // gaps in valid
    end
    drain();
    assert (seen == 32 / DEC_RATE) else report_value("metric count", 32 / DEC_RATE, seen);
    end_test();

    start_test("magnitudes_noise");
    send_noise(48, 32768);
    drain();
    end_test();

    start_test("preamble_detect");
    send_noise(24, 500);
    send_pattern(4, 1, 500);
    send_noise(24, 500);
    drain();
    assert (stb_cnt == 1) else report_value("strobes", 1, stb_cnt);
    end_test();

    start_test("noise_floor");
    send_pattern(4, 2, 50); // correlates well, power below the floor
    drain();
    assert (trig_cnt == 0) else report_value("triggers", 0, trig_cnt);
    assert (stb_cnt == 0) else report_value("strobes", 0, stb_cnt);
    end_test();

    start_test("rearm");
    send_pattern(3, 1, 500);
    send_noise(24, 500);
    send_pattern(3, 1, 500);
    send_noise(24, 500);
    drain();
    assert (stb_cnt == 2) else report_value("strobes", 2, stb_cnt);
    end_test();

    start_test("clear");
    send_pattern(2, 1, 500);
    send(pat_i[0], pat_q[0]);
    send(pat_i[1], pat_q[1]);
    idle(3); // last metric is about to leave the pipeline
    pulse_clear();
    send_pattern(3, 1, 500);
    send_noise(24, 500);
    drain();
    end_test();

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

/* project.f */
common/preamble_pkg.sv
common/iq_stream_if.sv
source/iq_decimator.sv
correlator/delay_correlator.sv
correlator/moving_sum.sv
source/trigger_metric.sv
source/peak_detect.sv
source/preamble_detect.sv
tests/preamble_detect_assert.sv
tests/tb_preamble_detect.sv

/* run_sim.sh */
#!/bin/sh
# Verilator build and run of the preamble detector testbench

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_preamble_detect -f project.f -o sim_tb
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "ERRORS FOUND" sim.log; then
  exit 1
fi
exit 0
